//--- Makefile
TOP = tb_trg_top

.PHONY: all lint clean

all:
	verilator --binary --assert -f list.f --top-module $(TOP) -o sim
	out=$$(./obj_dir/sim); echo "$$out"; echo "$$out" | grep -q "All tests passed!"

lint:
	verilator --lint-only --timing --assert -f list.f --top-module $(TOP)

clean:
	rm -rf obj_dir

//--- hw/baseline_cal.sv
`timescale 1ns/100ps

module baseline_cal import trg_pkg::*; (
    input  logic                   AXIS_ACLK,
    input  logic                   AXIS_ARESETN,
    input  exec_state_t            exec_state,
    input  logic [TDATA_WIDTH-1:0] s_axis_tdata,
    output logic [ADC_WIDTH-1:0]   baseline
);

    localparam int ACC_WIDTH = ADC_WIDTH + CAL_LOG;

    logic [ACC_WIDTH-1:0] acc;
    logic [ACC_WIDTH-1:0] acc_next;
    logic [ACC_WIDTH-1:0] slot0_ext;
    logic [CAL_LOG-1:0]   beat_cnt;
    logic                 in_init;

    assign in_init   = (exec_state == EXEC_INIT);
    assign slot0_ext = {{CAL_LOG{1'b0}}, s_axis_tdata[ADC_WIDTH-1:0]};

    // first calibration beat starts a fresh sum
    assign acc_next = (beat_cnt == '0) ? slot0_ext : acc + slot0_ext;

    always_ff @(posedge AXIS_ACLK)
    begin
        if (in_init)
            acc <= acc_next;
    end

    always_ff @(posedge AXIS_ACLK)
    begin
        if (!AXIS_ARESETN)
        begin
            beat_cnt <= '0;
            baseline <= '0;
        end
        else if (in_init)
        begin
            beat_cnt <= beat_cnt + 1'b1;
            // last beat of the window, average ready for the first armed beat
            if (beat_cnt == CAL_LOG'(CAL_BEATS - 1))
                baseline <= acc_next[ACC_WIDTH-1:CAL_LOG];
        end
        else
        begin
            beat_cnt <= '0;
        end
    end

endmodule

//--- hw/event_framer.sv
`timescale 1ns/100ps

module event_framer import trg_pkg::*; (
    input  logic                   AXIS_ACLK,
    input  logic                   AXIS_ARESETN,
    trig_if.dst                    trg,
    output logic [TDATA_WIDTH-1:0] m_tdata,
    output logic                   m_tvalid,
    output logic                   m_tuser,
    output logic                   m_tlast,
    output logic [TIME_WIDTH-1:0]  m_time_stamp,
    output logic [15:0]            event_count
);

    // falling edge of start_trg seen one cycle ahead of the output
    assign m_tlast = m_tvalid && !trg.start_trg;

    always_ff @(posedge AXIS_ACLK)
    begin
        if (!AXIS_ARESETN)
        begin
            m_tvalid    <= 1'b0;
            m_tuser     <= 1'b0;
            event_count <= '0;
        end
        else
        begin
            m_tvalid <= trg.start_trg;
            // rising edge, m_tvalid still holds the previous flag
            m_tuser  <= trg.start_trg && !m_tvalid;
            if (m_tlast)
                event_count <= event_count + 1'b1;
        end
    end

    always_ff @(posedge AXIS_ACLK)
    begin
        m_tdata      <= trg.tdata;
        m_time_stamp <= trg.time_stamp;
    end

    a_markers_valid: assert property (@(posedge AXIS_ACLK) disable iff (!AXIS_ARESETN)
        (m_tuser || m_tlast) |-> m_tvalid)
        else $error("record marker without m_tvalid");

    // a record only closes at the end of a post window
    a_last_after_window: assert property (@(posedge AXIS_ACLK) disable iff (!AXIS_ARESETN)
        m_tlast |-> $past(trg.finalize_trg))
        else $error("m_tlast outside the post window");

endmodule

//--- hw/run_control.sv
`timescale 1ns/100ps

module run_control import trg_pkg::*; (
    input  logic                  AXIS_ACLK,
    input  logic                  AXIS_ARESETN,
    input  logic                  run,
    input  logic                  stop,
    output exec_state_t           exec_state,
    output logic [TIME_WIDTH-1:0] current_time
);

    logic [CAL_LOG-1:0] cal_cnt;
    logic               start_run;

    // a run during calibration is ignored, stop always wins
    assign start_run = run && !stop && (exec_state != EXEC_INIT);

    always_ff @(posedge AXIS_ACLK)
    begin
        if (!AXIS_ARESETN)
        begin
            exec_state   <= EXEC_IDLE;
            cal_cnt      <= '0;
            current_time <= '0;
        end
        else
        begin
            // time base restarts at INIT entry
            if (start_run)
                current_time <= '0;
            else
                current_time <= current_time + 1'b1;

            if (stop)
            begin
                exec_state <= EXEC_IDLE;
            end
            else if (start_run)
            begin
                exec_state <= EXEC_INIT;
                cal_cnt    <= '0;
            end
            else if (exec_state == EXEC_INIT)
            begin
                cal_cnt <= cal_cnt + 1'b1;
                if (cal_cnt == CAL_LOG'(CAL_BEATS - 1))
                    exec_state <= EXEC_TRG;
            end
        end
    end

    // arming only ever follows a calibration window
    a_trg_from_init: assert property (@(posedge AXIS_ACLK) disable iff (!AXIS_ARESETN)
        ($changed(exec_state) && exec_state == EXEC_TRG) |-> $past(exec_state) == EXEC_INIT)
        else $error("exec_state entered TRG without calibration");

endmodule

//--- hw/threshold_trigger.sv
`timescale 1ns/100ps

module threshold_trigger import trg_pkg::*; (
    input  logic                   AXIS_ACLK,
    input  logic                   AXIS_ARESETN,
    input  exec_state_t            exec_state,
    input  logic [ADC_WIDTH-1:0]   baseline,
    input  logic [TIME_WIDTH-1:0]  current_time,
    input  logic [TDATA_WIDTH-1:0] s_axis_tdata,
    trig_if.src                    trg
);

    logic [SAMPLES_PER_BEAT-1:0] over;
    logic                        hot;
    logic                        zone;
    logic                        zone_d;
    logic [POST_CNT_WIDTH-1:0]   post_cnt;
    logic [TDATA_WIDTH-1:0]      tdata_d1;

    // per-slot subtract, clamped at zero so quiet dips never fire
    for (genvar i = 0; i < SAMPLES_PER_BEAT; i++)
    begin : g_slot
        logic [ADC_WIDTH-1:0] sample;
        logic [ADC_WIDTH-1:0] diff;

        assign sample  = s_axis_tdata[SLOT_WIDTH*i +: ADC_WIDTH];
        assign diff    = (sample > baseline) ? sample - baseline : '0;
        assign over[i] = (diff >= ADC_WIDTH'(THRESHOLD_VAL));
    end

    assign hot = (exec_state == EXEC_TRG) && (|over);

    always_ff @(posedge AXIS_ACLK)
    begin
        if (!AXIS_ARESETN)
        begin
            zone             <= 1'b0;
            zone_d           <= 1'b0;
            post_cnt         <= '0;
            trg.start_trg    <= 1'b0;
            trg.finalize_trg <= 1'b0;
        end
        else
        begin
            zone   <= hot;
            zone_d <= zone;

            if (zone)
            begin
                // active phase, also restarts a running window
                trg.start_trg    <= 1'b1;
                trg.finalize_trg <= 1'b0;
                post_cnt         <= '0;
            end
            else if (zone_d)
            begin
                // signal just fell back, open the window
                trg.start_trg    <= 1'b1;
                trg.finalize_trg <= 1'b1;
                post_cnt         <= POST_CNT_WIDTH'(1);
            end
            else if (trg.finalize_trg && post_cnt < POST_CNT_WIDTH'(POST_LEN))
            begin
                trg.start_trg    <= 1'b1;
                trg.finalize_trg <= 1'b1;
                post_cnt         <= post_cnt + 1'b1;
            end
            else
            begin
                trg.start_trg    <= 1'b0;
                trg.finalize_trg <= 1'b0;
                post_cnt         <= '0;
            end
        end
    end

    // two-stage data delay to line up with start_trg
    always_ff @(posedge AXIS_ACLK)
    begin
        tdata_d1  <= s_axis_tdata;
        trg.tdata <= tdata_d1;
        if (hot)
            trg.time_stamp <= current_time;
    end

    a_fin_with_start: assert property (@(posedge AXIS_ACLK) disable iff (!AXIS_ARESETN)
        trg.finalize_trg |-> trg.start_trg)
        else $error("finalize_trg high without start_trg");

    a_post_bound: assert property (@(posedge AXIS_ACLK) disable iff (!AXIS_ARESETN)
        post_cnt <= POST_CNT_WIDTH'(POST_LEN))
        else $error("post counter past window length");

endmodule

//--- hw/trg_pkg.sv
package trg_pkg;

    // stream geometry
    localparam int TDATA_WIDTH      = 128;
    localparam int SAMPLES_PER_BEAT = 8;
    localparam int SLOT_WIDTH       = 16;
    localparam int ADC_WIDTH        = 12;

    // time base
    localparam int TIME_WIDTH = 16;

    // threshold as a share of full scale, 4095 * 10 / 100 = 409
    localparam int THRESHOLD_PCT = 10;
    localparam int THRESHOLD_VAL = ((1 << ADC_WIDTH) - 1) * THRESHOLD_PCT / 100;

    // post-acquisition window in beats
    localparam int POST_LEN       = 38;
    localparam int POST_CNT_WIDTH = $clog2(POST_LEN + 1);

    // calibration window, a power of two so the average is a shift
    localparam int CAL_LOG   = 4;
    localparam int CAL_BEATS = 1 << CAL_LOG;

    typedef enum logic [1:0] {
        EXEC_INIT = 2'b00,
        EXEC_IDLE = 2'b01,
        EXEC_TRG  = 2'b11
    } exec_state_t;

endpackage

//--- hw/trg_top.sv
`timescale 1ns/100ps

module trg_top import trg_pkg::*; (
    input  logic                   AXIS_ACLK,
    input  logic                   AXIS_ARESETN,
    input  logic [TDATA_WIDTH-1:0] s_axis_tdata,
    input  logic                   run,
    input  logic                   stop,
    output exec_state_t            exec_state,
    output logic [ADC_WIDTH-1:0]   baseline,
    output logic [TDATA_WIDTH-1:0] m_tdata,
    output logic                   m_tvalid,
    output logic                   m_tuser,
    output logic                   m_tlast,
    output logic [TIME_WIDTH-1:0]  m_time_stamp,
    output logic [15:0]            event_count
);

    logic [TIME_WIDTH-1:0] current_time;

    trig_if trg_link ();

    run_control run_control_i (
        .AXIS_ACLK    (AXIS_ACLK),
        .AXIS_ARESETN (AXIS_ARESETN),
        .run          (run),
        .stop         (stop),
        .exec_state   (exec_state),
        .current_time (current_time)
    );

    baseline_cal baseline_cal_i (
        .AXIS_ACLK    (AXIS_ACLK),
        .AXIS_ARESETN (AXIS_ARESETN),
        .exec_state   (exec_state),
        .s_axis_tdata (s_axis_tdata),
        .baseline     (baseline)
    );

    threshold_trigger threshold_trigger_i (
        .AXIS_ACLK    (AXIS_ACLK),
        .AXIS_ARESETN (AXIS_ARESETN),
        .exec_state   (exec_state),
        .baseline     (baseline),
        .current_time (current_time),
        .s_axis_tdata (s_axis_tdata),
        .trg          (trg_link.src)
    );

    event_framer event_framer_i (
        .AXIS_ACLK    (AXIS_ACLK),
        .AXIS_ARESETN (AXIS_ARESETN),
        .trg          (trg_link.dst),
        .m_tdata      (m_tdata),
        .m_tvalid     (m_tvalid),
        .m_tuser      (m_tuser),
        .m_tlast      (m_tlast),
        .m_time_stamp (m_time_stamp),
        .event_count  (event_count)
    );

endmodule

//--- hw/trig_if.sv
`timescale 1ns/100ps

interface trig_if import trg_pkg::*; ();

    // levels, a record spans every cycle with start_trg high
    logic                   start_trg;
    logic                   finalize_trg;
    logic [TIME_WIDTH-1:0]  time_stamp;
    // input beat aligned with the flags
    logic [TDATA_WIDTH-1:0] tdata;

    modport src (
        output start_trg,
        output finalize_trg,
        output time_stamp,
        output tdata
    );

    modport dst (
        input start_trg,
        input finalize_trg,
        input time_stamp,
        input tdata
    );

endinterface

//--- list.f
hw/trg_pkg.sv
hw/trig_if.sv
hw/run_control.sv
hw/baseline_cal.sv
hw/threshold_trigger.sv
hw/event_framer.sv
hw/trg_top.sv
test/tb_trg_top.sv

//--- test/tb_trg_top.sv
`timescale 1ns/100ps

module tb_trg_top import trg_pkg::*; ();

    localparam int CLK_PERIOD  = 10;
    localparam int QUIET_LEVEL = 200;
    localparam int QUIET       = 12;
    localparam int REC_WAIT    = POST_LEN + 20;
    // idle, calibration, single pulse, threshold edge, retrigger, stop
    localparam int TEST_CYCLES = 5 + 50 + (CAL_BEATS + 2) + (QUIET + 4 + REC_WAIT)
        + (QUIET + 8 + POST_LEN + 10) + (QUIET + 15 + REC_WAIT) + (6 + POST_LEN + 10);
    localparam int WATCHDOG_NS = (TEST_CYCLES + 100) * CLK_PERIOD;

    logic                   AXIS_ACLK;
    logic                   AXIS_ARESETN;
    logic [TDATA_WIDTH-1:0] s_axis_tdata;
    logic                   run;
    logic                   stop;
    exec_state_t            exec_state;
    logic [ADC_WIDTH-1:0]   baseline;
    logic [TDATA_WIDTH-1:0] m_tdata;
    logic                   m_tvalid;
    logic                   m_tuser;
    logic                   m_tlast;
    logic [TIME_WIDTH-1:0]  m_time_stamp;
    logic [15:0]            event_count;

    integer                 seed = 32'h185e_18ec;
    int                     errors = 0;
    int                     checks = 0;
    int                     tests = 0;
    int                     test_err_base = 0;
    int                     cyc = 0;
    int                     init_cyc = 0;
    logic [ADC_WIDTH-1:0]   exp_baseline = '0;
    // finished records expected so far
    int                     exp_events = 0;
    // monitor view of the last finished record
    int                     rec_count = 0;
    int                     rec_len = 0;
    int                     cur_len = 0;
    int                     tuser_cyc = 0;
    logic [TDATA_WIDTH-1:0] rec_first;
    logic [TIME_WIDTH-1:0]  rec_ts;
    // stimulus side of the last burst
    int                     first_hot_cyc = 0;
    int                     last_hot_cyc = 0;
    logic [TDATA_WIDTH-1:0] first_hot_beat;

    trg_top trg_top_i (.*);

    initial
    begin
        AXIS_ACLK = 1'b0;
        forever #(CLK_PERIOD / 2) AXIS_ACLK = ~AXIS_ACLK;
    end

    always @(posedge AXIS_ACLK)
        cyc <= cyc + 1;

    // outputs are all registered, so the falling edge sees settled values
    always @(negedge AXIS_ACLK)
    begin
        if (AXIS_ARESETN && m_tvalid)
        begin
            if (m_tuser)
            begin
                cur_len = 0;
                tuser_cyc = cyc;
                rec_first = m_tdata;
            end
            cur_len++;
            if (m_tlast)
            begin
                rec_len = cur_len;
                rec_ts = m_time_stamp;
                rec_count++;
            end
        end
    end

    function automatic logic [TDATA_WIDTH-1:0] fill_beat(input logic [ADC_WIDTH-1:0] val);
        return {SAMPLES_PER_BEAT{4'h0, val}};
    endfunction

    // noise a few codes above the quiet level in every slot
    function automatic logic [TDATA_WIDTH-1:0] quiet_beat();
        logic [TDATA_WIDTH-1:0] beat;
        for (int i = 0; i < SAMPLES_PER_BEAT; i++)
            beat[SLOT_WIDTH*i +: SLOT_WIDTH] = 16'(QUIET_LEVEL + ($random(seed) & 31));
        return beat;
    endfunction

    function automatic logic [TDATA_WIDTH-1:0] hot_beat(input int slot);
        logic [TDATA_WIDTH-1:0] beat;
        beat = quiet_beat();
        beat[SLOT_WIDTH*slot +: SLOT_WIDTH] = 16'(exp_baseline + THRESHOLD_VAL);
        return beat;
    endfunction

    task automatic next_cycle();
        @(posedge AXIS_ACLK);
        #1;
    endtask

    task automatic check(input string name, input logic [127:0] got, input logic [127:0] exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("mismatch at %0t: %s = %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic finish_test(input string name);
        tests++;
        if (errors == test_err_base)
            $display("%s: ok", name);
        else
            $display("%s: %0d errors", name, errors - test_err_base);
        test_err_base = errors;
    endtask

    task automatic drive_quiet(input int n);
        repeat (n)
        begin
            next_cycle();
            s_axis_tdata = quiet_beat();
        end
    endtask

    task automatic drive_hot(input int n, input bit new_record);
        for (int i = 0; i < n; i++)
        begin
            next_cycle();
            s_axis_tdata = hot_beat(i % SAMPLES_PER_BEAT);
            if (new_record && i == 0)
            begin
                first_hot_cyc = cyc;
                first_hot_beat = s_axis_tdata;
            end
            last_hot_cyc = cyc;
        end
    endtask

    task automatic wait_record(input int target);
        int n;
        n = 0;
        while (rec_count < target && n < REC_WAIT)
        begin
            next_cycle();
            s_axis_tdata = quiet_beat();
            n++;
        end
        if (rec_count < target)
        begin
            errors++;
            $display("no record came out within %0d cycles at %0t", REC_WAIT, $time);
        end
    endtask

    task automatic check_record(input int len, input int events);
        check("record length", 128'(rec_len), 128'(len));
        check("m_tuser delay", 128'(tuser_cyc - first_hot_cyc), 128'(3));
        check("first m_tdata", rec_first, first_hot_beat);
        // time base counts from INIT entry
        check("m_time_stamp", 128'(rec_ts), 128'(16'(last_hot_cyc - init_cyc)));
        check("event_count", 128'(event_count), 128'(events));
    endtask

    task automatic check_no_record(input int target, input int events);
        check("record count", 128'(rec_count), 128'(target));
        check("event_count", 128'(event_count), 128'(events));
        check("m_tvalid", 128'(m_tvalid), 128'(0));
    endtask

    task automatic test_idle();
        s_axis_tdata = fill_beat(12'hfff);
        repeat (50)
        begin
            next_cycle();
            check("exec_state", 128'(exec_state), 128'(EXEC_IDLE));
            check("m_tvalid", 128'(m_tvalid), 128'(0));
        end
        check("event_count", 128'(event_count), 128'(exp_events));
        finish_test("reset and idle");
    endtask

    task automatic test_calibration();
        int sum;
        sum = 0;
        next_cycle();
        run = 1'b1;
        s_axis_tdata = quiet_beat();
        for (int i = 0; i < CAL_BEATS; i++)
        begin
            next_cycle();
            if (i == 0)
                init_cyc = cyc;
            run = 1'b0;
            check("exec_state", 128'(exec_state), 128'(EXEC_INIT));
            s_axis_tdata = quiet_beat();
            sum += int'(s_axis_tdata[ADC_WIDTH-1:0]);
        end
        next_cycle();
        exp_baseline = 12'(sum >> CAL_LOG);
        check("exec_state", 128'(exec_state), 128'(EXEC_TRG));
        check("baseline", 128'(baseline), 128'(exp_baseline));
        finish_test("calibration");
    endtask

    task automatic test_single_pulse();
        int target;
        target = rec_count + 1;
        drive_quiet(QUIET);
        drive_hot(4, 1'b1);
        wait_record(target);
        exp_events++;
        check_record(4 + POST_LEN, exp_events);
        finish_test("single pulse");
    endtask

    task automatic test_threshold_edge();
        int target;
        target = rec_count;
        drive_quiet(QUIET);
        repeat (4)
        begin
            next_cycle();
            s_axis_tdata = fill_beat(12'(exp_baseline + THRESHOLD_VAL - 1));
        end
        // below baseline, would wrap without saturation
        repeat (4)
        begin
            next_cycle();
            s_axis_tdata = fill_beat(12'(exp_baseline - 5));
        end
        drive_quiet(POST_LEN + 10);
        check_no_record(target, exp_events);
        finish_test("threshold edge");
    endtask

    task automatic test_retrigger();
        int target;
        target = rec_count + 1;
        drive_quiet(QUIET);
        drive_hot(3, 1'b1);
        drive_quiet(10);
        drive_hot(2, 1'b0);
        wait_record(target);
        exp_events++;
        // span of 3 + 10 + 2 beats from first to last hot beat
        check_record(15 + POST_LEN, exp_events);
        finish_test("retrigger in window");
    endtask

    task automatic test_stop();
        int target;
        target = rec_count;
        next_cycle();
        stop = 1'b1;
        next_cycle();
        stop = 1'b0;
        check("exec_state", 128'(exec_state), 128'(EXEC_IDLE));
        drive_hot(4, 1'b0);
        drive_quiet(POST_LEN + 10);
        check_no_record(target, exp_events);
        finish_test("stop");
    endtask

    initial
    begin
        AXIS_ARESETN = 1'b0;
        run = 1'b0;
        stop = 1'b0;
        s_axis_tdata = '0;
        repeat (5) @(posedge AXIS_ACLK);
        #1;
        AXIS_ARESETN = 1'b1;
        test_idle();
        test_calibration();
        test_single_pulse();
        test_threshold_edge();
        test_retrigger();
        test_stop();
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
        $display("Test failures found");
        $finish;
    end

endmodule
